// ==== bench/mem_1r1w_vectors.txt ====
# name vread vrdaddr vwrite vwraddr vdin expected_vdout (all hex)
# expected is checked one cycle after the read, - means no data check
wr_plain_a          0 00 1 05 11110001 -
wr_plain_b          0 00 1 0a 22220002 -
wr_plain_c          0 00 1 03 55550005 -
rd_plain_a          1 05 0 00 00000000 11110001
rd_plain_b          1 0a 0 00 00000000 22220002
conflict_div        1 05 1 09 33330003 11110001
rd_diverted         1 09 0 00 00000000 33330003
rd_reader           1 05 0 00 00000000 11110001
rd_row_mate         1 0a 0 00 00000000 22220002
evict_a             1 03 1 0b 44440004 55550005
rd_evicted_a        1 09 0 00 00000000 33330003
rd_new_cached_a     1 0b 0 00 00000000 44440004
same_addr           1 05 1 05 66660006 11110001
same_addr_next      1 05 0 00 00000000 66660006
same_cached         1 0b 1 0b 77770007 44440004
same_cached_next    1 0b 0 00 00000000 77770007
home_clear          0 00 1 05 88880008 -
home_read           1 05 0 00 00000000 88880008
div_after_clear     1 0a 1 06 99990009 22220002
rd_div_after_clear  1 06 0 00 00000000 99990009
rd_home_after       1 05 0 00 00000000 88880008
cache_rd_free_bank  1 06 1 02 aaaa000a 99990009
rd_free_bank        1 02 0 00 00000000 aaaa000a
wr_plain_d          0 00 1 00 bbbb000b -
evict_b             1 00 1 04 cccc000c bbbb000b
rd_evicted_b        1 06 0 00 00000000 99990009
rd_cached_b         1 04 0 00 00000000 cccc000c
rd_home_b           1 05 0 00 00000000 88880008
idle_a              0 00 0 00 00000000 -
same_cached_b       1 04 1 04 dddd000d cccc000c
same_cached_b_next  1 04 0 00 00000000 dddd000d
idle_b              0 00 0 00 00000000 -
wr_row15_b0         0 00 1 3c 0f000000 -
wr_row15_b1         0 00 1 3d 0f000001 -
wr_row15_b2         0 00 1 3e 0f000002 -
wr_row15_b3         0 00 1 3f 0f000003 -
rd_wr_chain_0       1 3c 1 3d 0f100001 0f000000
rd_wr_chain_1       1 3d 1 3e 0f100002 0f100001
rd_wr_chain_2       1 3e 1 3f 0f100003 0f100002
rd_wr_chain_3       1 3f 0 00 00000000 0f100003
evict_chain_a       1 3d 1 39 e1000001 0f100001
evict_chain_b       1 3e 1 3a e2000002 0f100002
evict_chain_c       1 3f 1 3b e3000003 0f100003
rd_chain_a          1 39 0 00 00000000 e1000001
rd_chain_b          1 3a 0 00 00000000 e2000002
rd_chain_c          1 3b 0 00 00000000 e3000003
idle_end            0 00 0 00 00000000 -

// ==== bench/tb_mem_1r1w.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_1r1w import mem_pkg::*; ();

  localparam int    MAX_VEC      = 256;
  localparam int    CLK_HALF     = 5;
  localparam int    RESET_CYCLES = 10;
  localparam int    INIT_CYCLES  = 17;
  localparam int    MARGIN       = 50;
  localparam string VEC_FILE     = "bench/mem_1r1w_vectors.txt";

  logic  clk;
  logic  rstvld;
  logic  vread;
  addr_t vrdaddr;
  logic  vwrite;
  addr_t vwraddr;
  data_t vdin;
  logic  ready;
  logic  vread_vld;
  data_t vdout;

  string vec_name   [MAX_VEC];
  logic  vec_rd     [MAX_VEC];
  addr_t vec_rdaddr [MAX_VEC];
  logic  vec_wr     [MAX_VEC];
  addr_t vec_wraddr [MAX_VEC];
  data_t vec_din    [MAX_VEC];
  logic  vec_chk    [MAX_VEC];
  data_t vec_exp    [MAX_VEC];
  int    num_vec;

  int check_cnt     = 0;
  int mismatch_cnt  = 0;
  int other_err_cnt = 0;
  int cycle_cnt     = 0;
  int cycle_limit   = 0;

  mem_1r1w_top dut0 (
    .clk       (clk),
    .rstvld    (rstvld),
    .vread     (vread),
    .vrdaddr   (vrdaddr),
    .vwrite    (vwrite),
    .vwraddr   (vwraddr),
    .vdin      (vdin),
    .ready     (ready),
    .vread_vld (vread_vld),
    .vdout     (vdout)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_HALF) clk = ~clk;
    end
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             check_cnt, mismatch_cnt, other_err_cnt);
  endtask

  task automatic drive_inputs(input logic rd, input addr_t rda, input logic wr,
                              input addr_t wra, input data_t din);
    vread   = rd;
    vrdaddr = rda;
    vwrite  = wr;
    vwraddr = wra;
    vdin    = din;
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    int    ch;
    string tok;
    string exp_tok;
    logic  rd;
    addr_t rda;
    logic  wr;
    addr_t wra;
    data_t din;
    data_t expv;
    logic  done;
    num_vec = 0;
    done    = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Error: cannot open vector file %s", VEC_FILE);
      other_err_cnt++;
    end else begin
      while (!done) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          done = 1'b1;
        end else if (tok.getc(0) == "#") begin
          // Comment runs to end of line
          ch = $fgetc(fd);
          while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %s", rd, rda, wr, wra, din, exp_tok);
          if (code != 6) begin
            $display("Error: vector line %s is incomplete", tok);
            other_err_cnt++;
            done = 1'b1;
          end else if (num_vec >= MAX_VEC) begin
            $display("Error: vector file holds more than %0d lines", MAX_VEC);
            other_err_cnt++;
            done = 1'b1;
          end else begin
            vec_name[num_vec]   = tok;
            vec_rd[num_vec]     = rd;
            vec_rdaddr[num_vec] = rda;
            vec_wr[num_vec]     = wr;
            vec_wraddr[num_vec] = wra;
            vec_din[num_vec]    = din;
            vec_chk[num_vec]    = 1'b0;
            vec_exp[num_vec]    = '0;
            if (exp_tok != "-") begin
              code = $sscanf(exp_tok, "%h", expv);
              vec_chk[num_vec] = 1'b1;
              vec_exp[num_vec] = expv;
            end
            num_vec++;
          end
        end
      end
      $fclose(fd);
      if (num_vec == 0) begin
        $display("Error: vector file holds no test lines");
        other_err_cnt++;
      end
    end
  endtask

  // Outputs seen after each edge belong to the line driven one cycle before
  task automatic run_vectors();
    int i;
    for (i = 0; i <= num_vec; i++) begin
      if (i > 0) begin
        check_flag(vec_name[i-1], vec_rd[i-1], vread_vld);
        if (vec_chk[i-1]) begin
          check_data(vec_name[i-1], vec_exp[i-1], vdout);
        end
      end
      if (i < num_vec) begin
        drive_inputs(vec_rd[i], vec_rdaddr[i], vec_wr[i], vec_wraddr[i], vec_din[i]);
      end else begin
        drive_inputs(1'b0, '0, 1'b0, '0, '0);
      end
      @(posedge clk);
      #1;
    end
    check_flag("drain", 1'b0, vread_vld);
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Error: run did not finish within %0d cycles", cycle_limit);
      other_err_cnt++;
      print_counts();
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int i;
    int wait_cnt;
    rstvld = 1'b1;
    drive_inputs(1'b0, '0, 1'b0, '0, '0);
    load_vectors();
    cycle_limit = num_vec + INIT_CYCLES + MARGIN;

    for (i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #1;
      check_flag("reset_ready", 1'b0, ready);
      check_flag("reset_vld", 1'b0, vread_vld);
    end
    rstvld = 1'b0;

    // A read during the sweep must be dropped
    drive_inputs(1'b1, 6'h05, 1'b0, '0, '0);
    for (i = 0; i < `MEM_NUMVROW; i++) begin
      @(posedge clk);
      #1;
      check_flag("init_ready", 1'b0, ready);
      check_flag("init_vld", 1'b0, vread_vld);
    end

    wait_cnt = 0;
    while (ready !== 1'b1 && wait_cnt < INIT_CYCLES + MARGIN) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (ready !== 1'b1) begin
      $display("Error: ready did not rise within %0d cycles after the sweep",
               INIT_CYCLES + MARGIN);
      other_err_cnt++;
    end else begin
      run_vectors();
    end

    print_counts();
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/bank_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module bank_router import mem_pkg::*; (
  input  logic  clk,
  input  logic  init_busy,
  input  row_t  init_row,
  input  logic  rd_en,
  input  bank_t rd_bank,
  input  row_t  rd_row,
  input  logic  wr_en,
  input  bank_t wr_bank,
  input  row_t  wr_row,
  input  data_t wr_data,
  output logic  rd_fire,
  output data_t rd_data
);

  map_entry_t rd_map;
  map_entry_t wr_map;
  logic       map_we;
  row_t       map_waddr;
  map_entry_t map_wdata;

  row_t       cache_raddr;
  data_t      cache_rdata;
  logic       cache_we;

  data_t      bank_rdata [`MEM_NUMVBNK];

  logic       rd_from_cache;
  logic       conflict;
  logic       home_wr;
  logic       map_clear;
  logic       evict;
  bank_t      evict_bank;

  // Map table has one copy per lookup port and both are written alike
  row_store #(.row_type(map_entry_t)) map_rd_copy (
    .clk   (clk),
    .we    (map_we),
    .waddr (map_waddr),
    .wdata (map_wdata),
    .raddr (rd_row),
    .rdata (rd_map)
  );

  row_store #(.row_type(map_entry_t)) map_wr_copy (
    .clk   (clk),
    .we    (map_we),
    .waddr (map_waddr),
    .wdata (map_wdata),
    .raddr (wr_row),
    .rdata (wr_map)
  );

  assign rd_from_cache = rd_en && rd_map.vld && (rd_map.bank == rd_bank);

  // Read owns the bank so the write has to go to the cache
  assign conflict = wr_en && rd_en && !rd_from_cache && (rd_bank == wr_bank);
  assign home_wr  = wr_en && !conflict;
  assign cache_we = conflict;

  assign map_clear  = home_wr && wr_map.vld && (wr_map.bank == wr_bank);
  assign evict      = conflict && wr_map.vld && (wr_map.bank != wr_bank);
  assign evict_bank = wr_map.bank;

  always_comb begin
    map_we    = 1'b0;
    map_waddr = wr_row;
    map_wdata = '0;
    if (init_busy) begin
      map_we    = 1'b1;
      map_waddr = init_row;
    end else if (cache_we) begin
      map_we         = 1'b1;
      map_wdata.vld  = 1'b1;
      map_wdata.bank = wr_bank;
    end else if (map_clear) begin
      map_we = 1'b1;
    end
  end

  // Eviction only happens when the read is not on the cache
  assign cache_raddr = rd_from_cache ? rd_row : wr_row;

  row_store #(.row_type(data_t)) cache_bank (
    .clk   (clk),
    .we    (cache_we),
    .waddr (wr_row),
    .wdata (wr_data),
    .raddr (cache_raddr),
    .rdata (cache_rdata)
  );

  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    logic  evict_here;
    logic  bank_we;
    data_t bank_wdata;

    assign evict_here = evict && (evict_bank == bank_t'(b));
    assign bank_we    = (home_wr && (wr_bank == bank_t'(b))) || evict_here;
    assign bank_wdata = evict_here ? cache_rdata : wr_data;

    row_store #(.row_type(data_t)) data_bank (
      .clk   (clk),
      .we    (bank_we),
      .waddr (wr_row),
      .wdata (bank_wdata),
      .raddr (rd_row),
      .rdata (bank_rdata[b])
    );

    // Diverted write leaves its home bank untouched, eviction included
    a_evict_not_wr_bank: assert property (
      @(posedge clk) (conflict && (wr_bank == bank_t'(b))) |-> !bank_we
    );
  end

  assign rd_fire = rd_en;
  assign rd_data = rd_from_cache ? cache_rdata : bank_rdata[rd_bank];

  // Evicted word must not land in the bank being read
  a_evict_not_rd_bank: assert property (
    @(posedge clk) evict |-> (evict_bank != rd_bank)
  );

endmodule

`default_nettype wire

// ==== design/mem_1r1w_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_1r1w_top import mem_pkg::*; (
  input  logic  clk,
  input  logic  rstvld,
  input  logic  vread,
  input  addr_t vrdaddr,
  input  logic  vwrite,
  input  addr_t vwraddr,
  input  data_t vdin,
  output logic  ready,
  output logic  vread_vld,
  output data_t vdout
);

  logic  init_busy;
  row_t  init_row;
  logic  rd_en;
  bank_t rd_bank;
  row_t  rd_row;
  logic  wr_en;
  bank_t wr_bank;
  row_t  wr_row;
  data_t wr_data;

  logic  rd_fire;
  data_t rd_data;

  // Decode
  req_decode u_decode (
    .clk       (clk),
    .rstvld    (rstvld),
    .vread     (vread),
    .vrdaddr   (vrdaddr),
    .vwrite    (vwrite),
    .vwraddr   (vwraddr),
    .vdin      (vdin),
    .ready     (ready),
    .init_busy (init_busy),
    .init_row  (init_row),
    .rd_en     (rd_en),
    .rd_bank   (rd_bank),
    .rd_row    (rd_row),
    .wr_en     (wr_en),
    .wr_bank   (wr_bank),
    .wr_row    (wr_row),
    .wr_data   (wr_data)
  );

  // Execute stage with banks, cache and map table
  bank_router u_router (
    .clk       (clk),
    .init_busy (init_busy),
    .init_row  (init_row),
    .rd_en     (rd_en),
    .rd_bank   (rd_bank),
    .rd_row    (rd_row),
    .wr_en     (wr_en),
    .wr_bank   (wr_bank),
    .wr_row    (wr_row),
    .wr_data   (wr_data),
    .rd_fire   (rd_fire),
    .rd_data   (rd_data)
  );

  // Result
  read_return u_return (
    .clk       (clk),
    .rstvld    (rstvld),
    .rd_fire   (rd_fire),
    .rd_data   (rd_data),
    .vread_vld (vread_vld),
    .vdout     (vdout)
  );

endmodule

`default_nettype wire

// ==== design/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Data word
`define MEM_WIDTH   32

// Data banks without the spare cache bank
`define MEM_NUMVBNK 4
`define MEM_BITVBNK 2

// Rows per bank
`define MEM_NUMVROW 16
`define MEM_BITVROW 4

// Flat address holds the row in the upper bits and the bank in the lower bits
`define MEM_BITADDR 6

`endif

// ==== design/mem_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

  // Flat virtual address
  typedef logic [`MEM_BITADDR-1:0] addr_t;

  typedef logic [`MEM_BITVBNK-1:0] bank_t;

  typedef logic [`MEM_BITVROW-1:0] row_t;

  typedef logic [`MEM_WIDTH-1:0] data_t;

  // Cache row holds the word of bank when vld is set
  typedef struct packed {
    logic  vld;
    bank_t bank;
  } map_entry_t;

endpackage

`default_nettype wire

// ==== design/read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return import mem_pkg::*; (
  input  logic  clk,
  input  logic  rstvld,
  input  logic  rd_fire,
  input  data_t rd_data,
  output logic  vread_vld,
  output data_t vdout
);

  always_ff @(posedge clk) begin
    if (rstvld) begin
      vread_vld <= 1'b0;
    end else begin
      vread_vld <= rd_fire;
    end
  end

  // Data holds its last value between reads
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      vdout <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module req_decode import mem_pkg::*; (
  input  logic  clk,
  input  logic  rstvld,
  input  logic  vread,
  input  addr_t vrdaddr,
  input  logic  vwrite,
  input  addr_t vwraddr,
  input  data_t vdin,
  output logic  ready,
  output logic  init_busy,
  output row_t  init_row,
  output logic  rd_en,
  output bank_t rd_bank,
  output row_t  rd_row,
  output logic  wr_en,
  output bank_t wr_bank,
  output row_t  wr_row,
  output data_t wr_data
);

  // One extra bit so the count can sit past the last row
  logic [`MEM_BITVROW:0] init_cnt;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      init_cnt <= '0;
    end else if (init_busy) begin
      init_cnt <= init_cnt + 1'b1;
    end
  end

  assign init_busy = (init_cnt < `MEM_NUMVROW);
  assign init_row  = init_cnt[`MEM_BITVROW-1:0];

  always_ff @(posedge clk) begin
    if (rstvld) begin
      ready <= 1'b0;
    end else begin
      ready <= !init_busy;
    end
  end

  // Requests outside ready are dropped
  assign rd_en = vread && ready;
  assign wr_en = vwrite && ready;

  assign rd_bank = vrdaddr[`MEM_BITVBNK-1:0];
  assign rd_row  = vrdaddr[`MEM_BITVBNK +: `MEM_BITVROW];
  assign wr_bank = vwraddr[`MEM_BITVBNK-1:0];
  assign wr_row  = vwraddr[`MEM_BITVBNK +: `MEM_BITVROW];
  assign wr_data = vdin;

  // Map clearing must finish before any request reaches the banks
  a_no_req_in_init: assert property (
    @(posedge clk) disable iff (rstvld) !((rd_en || wr_en) && init_busy)
  );

endmodule

`default_nettype wire

// ==== design/row_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module row_store #(
  parameter type row_type = logic [`MEM_WIDTH-1:0]
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [`MEM_BITVROW-1:0] waddr,
  input  row_type                 wdata,
  input  logic [`MEM_BITVROW-1:0] raddr,
  output row_type                 rdata
);

  row_type mem [`MEM_NUMVROW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read is asynchronous so a same-cycle write shows up only next cycle
  assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/mem_pkg.sv
design/row_store.sv
design/req_decode.sv
design/bank_router.sv
design/read_return.sv
design/mem_1r1w_top.sv
bench/tb_mem_1r1w.sv
